/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exec_backend
FILELIST  ?= exec_backend.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* exec_backend.f */
source/be_pkg.sv
source/exec_unit.sv
source/ex_mem_reg.sv
source/data_ram.sv
source/mem_stage.sv
source/exec_backend.sv
tests/tb_exec_backend.sv

/* source/be_pkg.sv */
package be_pkg;

    typedef enum logic [4:0] {
        NOP   = 5'd0,
        ADD   = 5'd1,
        SUB   = 5'd2,
        AND   = 5'd3,
        OR    = 5'd4,
        XOR   = 5'd5,
        SLT   = 5'd6,
        SLTU  = 5'd7,
        SLL   = 5'd8,
        SRL   = 5'd9,
        LDW   = 5'd10,
        LDB   = 5'd11,
        LDBU  = 5'd12,
        STW   = 5'd13,
        STB   = 5'd14,
        CSRRD = 5'd15,
        CSRWR = 5'd16
    } be_op_e;

    // LoongArch exception codes.
    typedef enum logic [5:0] {
        NONE = 6'h00,
        ALE  = 6'h09,
        SYS  = 6'h0b,
        BRK  = 6'h0c,
        INE  = 6'h0d
    } be_ecode_e;

    typedef struct packed {
        logic [17:0] rsvd;
        logic [13:0] num;
    } be_csr_view_t;

    // Byte address for loads and stores or CSR number for CSR ops.
    typedef union packed {
        logic [31:0]  byte_addr;
        be_csr_view_t csr;
    } be_addr_u;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        be_op_e      op;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic        wen;
        logic [13:0] csr_num;
        logic        excp;
        be_ecode_e   ecode;
    } be_issue_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        be_op_e      op;
        logic [4:0]  rd;
        logic        wen;
        logic [31:0] result;
        be_addr_u    addr;
        logic [31:0] store_data;
        logic        csr_we;
        logic [31:0] csr_wdata;
        logic        excp;
        be_ecode_e   ecode;
    } be_exmem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        wen;
        logic [31:0] wdata;
        logic        csr_we;
        logic [13:0] csr_num;
        logic [31:0] csr_wdata;
        logic        excp;
        be_ecode_e   ecode;
    } be_wb_t;

    function automatic logic is_load(be_op_e op);
        return (op == LDW) || (op == LDB) || (op == LDBU);
    endfunction

    function automatic logic is_store(be_op_e op);
        return (op == STW) || (op == STB);
    endfunction

    function automatic logic is_csr(be_op_e op);
        return (op == CSRRD) || (op == CSRWR);
    endfunction

endpackage

/* source/data_ram.sv */
module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         we_i,
    input  logic [3:0]                   be_i,
    input  logic [$clog2(RAM_WORDS)-1:0] idx_i,
    input  logic [31:0]                  wdata_i,
    output logic [31:0]                  rdata_o
);

    logic [31:0] mem [RAM_WORDS];

    // Byte lanes are written independently.
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign rdata_o = mem[idx_i];

endmodule

/* source/ex_mem_reg.sv */
module ex_mem_reg
    import be_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      stall_i,
    input  logic      flush_i,
    input  logic      excp_flush_i,
    input  logic      ertn_flush_i,
    input  be_exmem_t ex_i,
    output be_exmem_t mem_o
);

    logic flush_any;

    assign flush_any = flush_i || excp_flush_i || ertn_flush_i;

    // Flush beats stall.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_o <= '0;
        end else if (flush_any) begin
            mem_o <= '0;
        end else if (!stall_i) begin
            mem_o <= ex_i;
        end
    end

    // A flushed slot must come out as a bubble.
    a_flush_bubble: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        flush_any |=> !mem_o.valid && !mem_o.wen && !mem_o.csr_we && !mem_o.excp
    ) else $error("ex_mem_reg kept a live entry after flush");

endmodule

/* source/exec_backend.sv */
module exec_backend
    import be_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        stall_i,
    input  logic        flush_i,
    input  logic        excp_flush_i,
    input  logic        ertn_flush_i,
    input  be_issue_t   issue_i,
    input  logic [31:0] csr_rdata_i,
    output be_wb_t      wb_o
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    be_exmem_t   ex_o;
    be_exmem_t   mem_q;
    logic        ram_we;
    logic [3:0]  ram_be;
    logic [IDX_W-1:0] ram_idx;
    logic [31:0] ram_wdata;
    logic [31:0] ram_rdata;

    exec_unit u_exec_unit (
        .issue_i     (issue_i),
        .csr_rdata_i (csr_rdata_i),
        .ex_o        (ex_o)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .ex_i         (ex_o),
        .mem_o        (mem_q)
    );

    mem_stage #(
        .RAM_WORDS (RAM_WORDS)
    ) u_mem_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .mem_i        (mem_q),
        .ram_rdata_i  (ram_rdata),
        .ram_we_o     (ram_we),
        .ram_be_o     (ram_be),
        .ram_idx_o    (ram_idx),
        .ram_wdata_o  (ram_wdata),
        .wb_o         (wb_o)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .be_i    (ram_be),
        .idx_i   (ram_idx),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

/* source/exec_unit.sv */
module exec_unit
    import be_pkg::*;
(
    input  be_issue_t   issue_i,
    input  logic [31:0] csr_rdata_i,
    output be_exmem_t   ex_o
);

    logic [31:0] alu_res;
    logic [31:0] mem_addr;
    logic [4:0]  shamt;
    logic        mem_op;
    logic        word_acc;
    logic        misalign;
    logic        fault;

    assign shamt    = issue_i.src2[4:0];
    assign mem_op   = is_load(issue_i.op) || is_store(issue_i.op);
    assign mem_addr = issue_i.src1 + issue_i.imm;

    // Only word accesses need alignment.
    assign word_acc = (issue_i.op == LDW) || (issue_i.op == STW);
    assign misalign = word_acc && (mem_addr[1:0] != 2'b00);

    // An incoming exception wins over a local one.
    assign fault = issue_i.valid && (issue_i.excp || misalign);

    always_comb begin
        case (issue_i.op)
            ADD: begin
                alu_res = issue_i.src1 + issue_i.src2;
            end
            SUB: begin
                alu_res = issue_i.src1 - issue_i.src2;
            end
            AND: begin
                alu_res = issue_i.src1 & issue_i.src2;
            end
            OR: begin
                alu_res = issue_i.src1 | issue_i.src2;
            end
            XOR: begin
                alu_res = issue_i.src1 ^ issue_i.src2;
            end
            SLT: begin
                alu_res = {31'b0, $signed(issue_i.src1) < $signed(issue_i.src2)};
            end
            SLTU: begin
                alu_res = {31'b0, issue_i.src1 < issue_i.src2};
            end
            SLL: begin
                alu_res = issue_i.src1 << shamt;
            end
            SRL: begin
                alu_res = issue_i.src1 >> shamt;
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    always_comb begin
        ex_o       = '0;
        ex_o.valid = issue_i.valid;
        ex_o.pc    = issue_i.pc;
        ex_o.op    = issue_i.op;
        ex_o.rd    = issue_i.rd;
        ex_o.wen   = issue_i.valid && issue_i.wen && !fault;

        if (mem_op) begin
            ex_o.addr.byte_addr = mem_addr;
            ex_o.store_data     = issue_i.src2;
        end else if (is_csr(issue_i.op)) begin
            ex_o.addr.csr.num = issue_i.csr_num;
            // Old CSR value goes to rd for both CSR ops.
            ex_o.result = csr_rdata_i;
            if (issue_i.op == CSRWR) begin
                ex_o.csr_we    = issue_i.valid && !fault;
                ex_o.csr_wdata = issue_i.src2;
            end
        end else begin
            ex_o.result = alu_res;
        end

        ex_o.excp = fault;
        if (issue_i.valid && issue_i.excp) begin
            ex_o.ecode = issue_i.ecode;
        end else if (fault) begin
            ex_o.ecode = ALE;
        end
    end

endmodule

/* source/mem_stage.sv */
module mem_stage
    import be_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         stall_i,
    input  logic                         flush_i,
    input  logic                         excp_flush_i,
    input  logic                         ertn_flush_i,
    input  be_exmem_t                    mem_i,
    input  logic [31:0]                  ram_rdata_i,
    output logic                         ram_we_o,
    output logic [3:0]                   ram_be_o,
    output logic [$clog2(RAM_WORDS)-1:0] ram_idx_o,
    output logic [31:0]                  ram_wdata_o,
    output be_wb_t                       wb_o
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic        flush_any;
    logic [1:0]  lane;
    logic [7:0]  ld_byte;
    logic [31:0] ld_data;
    be_wb_t      wb_d;

    assign flush_any = flush_i || excp_flush_i || ertn_flush_i;
    assign lane      = mem_i.addr.byte_addr[1:0];
    assign ram_idx_o = mem_i.addr.byte_addr[IDX_W+1:2];

    // A store being flushed in this cycle must not reach memory.
    assign ram_we_o = mem_i.valid && is_store(mem_i.op) && !mem_i.excp
                      && !stall_i && !flush_any;

    always_comb begin
        if (mem_i.op == STB) begin
            ram_be_o    = 4'b0001 << lane;
            ram_wdata_o = {4{mem_i.store_data[7:0]}};
        end else begin
            ram_be_o    = 4'b1111;
            ram_wdata_o = mem_i.store_data;
        end
    end

    assign ld_byte = ram_rdata_i[8*lane +: 8];

    always_comb begin
        case (mem_i.op)
            LDB: begin
                ld_data = {{24{ld_byte[7]}}, ld_byte};
            end
            LDBU: begin
                ld_data = {24'b0, ld_byte};
            end
            default: begin
                ld_data = ram_rdata_i;
            end
        endcase
    end

    always_comb begin
        wb_d           = '0;
        wb_d.valid     = mem_i.valid;
        wb_d.pc        = mem_i.pc;
        wb_d.rd        = mem_i.rd;
        wb_d.wen       = mem_i.wen;
        wb_d.wdata     = is_load(mem_i.op) ? ld_data : mem_i.result;
        wb_d.csr_we    = mem_i.csr_we;
        wb_d.csr_wdata = mem_i.csr_wdata;
        wb_d.excp      = mem_i.excp;
        wb_d.ecode     = mem_i.ecode;
        if (is_csr(mem_i.op)) begin
            wb_d.csr_num = mem_i.addr.csr.num;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_o <= '0;
        end else if (flush_any) begin
            wb_o <= '0;
        end else if (!stall_i) begin
            wb_o <= wb_d;
        end
    end

    // Faulting accesses never write memory.
    a_no_write_on_excp: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        mem_i.excp |-> !ram_we_o
    ) else $error("RAM write issued for an excepting instruction");

endmodule

/* tests/tb_exec_backend.sv */
module tb_exec_backend
    import be_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 20;
    localparam int STALL_LEN  = 5;
    // Reset, alu, memory, stall, three flushes, misaligned, csr.
    localparam int TEST_CYCLES    = 8 + 20 + 11 + (STALL_LEN + 8) + 3 * 9 + 10 + 6;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        stall_i;
    logic        flush_i;
    logic        excp_flush_i;
    logic        ertn_flush_i;
    be_issue_t   issue_i;
    logic [31:0] csr_rdata_i;
    be_wb_t      wb_o;

    int          seed = 32'hade4_b361;
    int          wr_cnt = 0;
    logic [31:0] next_pc;
    logic [31:0] mem_model [256];
    be_issue_t   prog_q[$];

    exec_backend #(
        .RAM_WORDS (256)
    ) i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .issue_i      (issue_i),
        .csr_rdata_i  (csr_rdata_i),
        .wb_o         (wb_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Counts RAM writes as they land.
    always @(posedge clk) begin
        if (rst_n_i && i_dut.ram_we) begin
            wr_cnt <= wr_cnt + 1;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("TESTBENCH FAILED");
        $fatal(1, "Watchdog expired before the tests finished.");
    end

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "Value mismatch in %s.", name);
        end
    endtask

    task automatic check_wb(input string name, input be_wb_t exp, input be_wb_t act);
        check_word({name, " valid"}, 32'(exp.valid), 32'(act.valid));
        check_word({name, " pc"}, exp.pc, act.pc);
        check_word({name, " rd"}, 32'(exp.rd), 32'(act.rd));
        check_word({name, " wen"}, 32'(exp.wen), 32'(act.wen));
        // Write data of a faulting instruction is undefined.
        if (!exp.excp) begin
            check_word({name, " wdata"}, exp.wdata, act.wdata);
        end
        check_word({name, " csr_we"}, 32'(exp.csr_we), 32'(act.csr_we));
        check_word({name, " csr_num"}, 32'(exp.csr_num), 32'(act.csr_num));
        check_word({name, " csr_wdata"}, exp.csr_wdata, act.csr_wdata);
        check_word({name, " excp"}, 32'(exp.excp), 32'(act.excp));
        check_word({name, " ecode"}, 32'(exp.ecode), 32'(act.ecode));
    endtask

    function automatic be_issue_t make_ins(input be_op_e op, input logic [31:0] src1,
                                           input logic [31:0] src2, input logic [31:0] imm,
                                           input logic wen);
        be_issue_t   ins;
        logic [31:0] r;
        r           = $random(seed);
        ins         = '0;
        ins.valid   = 1'b1;
        ins.pc      = next_pc;
        ins.op      = op;
        ins.src1    = src1;
        ins.src2    = src2;
        ins.imm     = imm;
        ins.rd      = r[4:0];
        ins.wen     = wen;
        ins.csr_num = r[31:18];
        next_pc     = next_pc + 32'd4;
        return ins;
    endfunction

    // Reference model that also tracks memory contents.
    function automatic be_wb_t predict_wb(input be_issue_t ins, input logic [31:0] csr_val);
        be_wb_t      w;
        logic [31:0] addr;
        logic [31:0] word;
        logic [4:0]  sh;
        logic [7:0]  b;
        logic        bad;
        w    = '0;
        addr = ins.src1 + ins.imm;
        sh   = {addr[1:0], 3'b000};
        word = mem_model[addr[9:2]];
        b    = word[sh +: 8];
        bad  = ins.excp || (((ins.op == LDW) || (ins.op == STW)) && (addr[1:0] != 2'b00));
        w.valid = 1'b1;
        w.pc    = ins.pc;
        w.rd    = ins.rd;
        w.wen   = ins.wen && !bad;
        w.excp  = bad;
        if (ins.excp) begin
            w.ecode = ins.ecode;
        end else if (bad) begin
            w.ecode = ALE;
        end
        case (ins.op)
            ADD:   w.wdata = ins.src1 + ins.src2;
            SUB:   w.wdata = ins.src1 - ins.src2;
            AND:   w.wdata = ins.src1 & ins.src2;
            OR:    w.wdata = ins.src1 | ins.src2;
            XOR:   w.wdata = ins.src1 ^ ins.src2;
            SLT:   w.wdata = ($signed(ins.src1) < $signed(ins.src2)) ? 32'd1 : 32'd0;
            SLTU:  w.wdata = (ins.src1 < ins.src2) ? 32'd1 : 32'd0;
            SLL:   w.wdata = ins.src1 << ins.src2[4:0];
            SRL:   w.wdata = ins.src1 >> ins.src2[4:0];
            LDW:   w.wdata = word;
            LDB:   w.wdata = {{24{b[7]}}, b};
            LDBU:  w.wdata = {24'b0, b};
            STW: begin
                if (!bad) mem_model[addr[9:2]] = ins.src2;
            end
            STB: begin
                if (!bad) mem_model[addr[9:2]][sh +: 8] = ins.src2[7:0];
            end
            CSRRD: begin
                w.wdata   = csr_val;
                w.csr_num = ins.csr_num;
            end
            CSRWR: begin
                w.wdata     = csr_val;
                w.csr_num   = ins.csr_num;
                w.csr_we    = !bad;
                w.csr_wdata = ins.src2;
            end
            default: ;
        endcase
        return w;
    endfunction

    // Issues the queued program back to back and checks each result two edges later.
    task automatic run_prog(input string name);
        be_wb_t      exp_q[$];
        logic [31:0] cv;
        int          n;
        n = prog_q.size();
        for (int i = 0; i < n + 2; i++) begin
            @(posedge clk);
            if (i < n) begin
                cv = $random(seed);
                csr_rdata_i <= cv;
                issue_i     <= prog_q[i];
                exp_q.push_back(predict_wb(prog_q[i], cv));
            end else begin
                issue_i <= '0;
            end
            @(negedge clk);
            if (i >= 2) begin
                check_wb(name, exp_q.pop_front(), wb_o);
            end
        end
        prog_q.delete();
    endtask

    task automatic run_alu_ops();
        be_op_e ops[9] = '{ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL};
        for (int k = 0; k < 18; k++) begin
            prog_q.push_back(make_ins(ops[k % 9], $random(seed), $random(seed), 32'h0, 1'b1));
        end
        run_prog("alu");
    endtask

    task automatic mem_round_trip();
        prog_q.push_back(make_ins(STW, 32'h30, $random(seed), 32'h10, 1'b0));
        prog_q.push_back(make_ins(LDW, 32'h30, 32'h0, 32'h10, 1'b1));
        prog_q.push_back(make_ins(STW, 32'h44, 32'h1122_3344, 32'h0, 1'b0));
        prog_q.push_back(make_ins(STB, 32'h44, 32'h5a5a_5a9c, 32'h1, 1'b0));
        prog_q.push_back(make_ins(STB, 32'h44, 32'h0000_007e, 32'h3, 1'b0));
        prog_q.push_back(make_ins(LDB, 32'h44, 32'h0, 32'h1, 1'b1));
        prog_q.push_back(make_ins(LDBU, 32'h44, 32'h0, 32'h1, 1'b1));
        prog_q.push_back(make_ins(LDB, 32'h44, 32'h0, 32'h3, 1'b1));
        prog_q.push_back(make_ins(LDW, 32'h44, 32'h0, 32'h0, 1'b1));
        run_prog("memory");
    endtask

    task automatic stall_hold();
        be_issue_t a;
        be_issue_t st;
        be_issue_t ld;
        be_wb_t    exp_a;
        be_wb_t    exp_st;
        be_wb_t    exp_ld;
        int        writes;
        a      = make_ins(ADD, $random(seed), $random(seed), 32'h0, 1'b1);
        st     = make_ins(STW, 32'h80, $random(seed), 32'h0, 1'b0);
        ld     = make_ins(LDW, 32'h80, 32'h0, 32'h0, 1'b1);
        exp_a  = predict_wb(a, 32'h0);
        exp_st = predict_wb(st, 32'h0);
        exp_ld = predict_wb(ld, 32'h0);
        @(posedge clk);
        issue_i <= a;
        @(posedge clk);
        issue_i <= st;
        // Store sits in the memory stage while stalled.
        @(posedge clk);
        issue_i <= ld;
        stall_i <= 1'b1;
        @(negedge clk);
        check_wb("stall", exp_a, wb_o);
        writes = wr_cnt;
        repeat (STALL_LEN) begin
            @(negedge clk);
            check_wb("stall hold", exp_a, wb_o);
        end
        @(posedge clk);
        stall_i <= 1'b0;
        @(posedge clk);
        issue_i <= '0;
        @(negedge clk);
        check_wb("stall release", exp_st, wb_o);
        @(negedge clk);
        check_wb("stall release", exp_ld, wb_o);
        check_word("stall store writes", 32'(writes + 1), 32'(wr_cnt));
    endtask

    task automatic flush_pulse(input string name, input int sel);
        be_issue_t st;
        be_issue_t alu;
        st  = make_ins(STW, 32'h40, $random(seed), 32'h0, 1'b0);
        alu = make_ins(ADD, $random(seed), $random(seed), 32'h0, 1'b1);
        @(posedge clk);
        issue_i <= st;
        @(posedge clk);
        issue_i      <= alu;
        flush_i      <= (sel == 0);
        excp_flush_i <= (sel == 1);
        ertn_flush_i <= (sel == 2);
        @(posedge clk);
        issue_i      <= '0;
        flush_i      <= 1'b0;
        excp_flush_i <= 1'b0;
        ertn_flush_i <= 1'b0;
        @(negedge clk);
        check_wb(name, '0, wb_o);
        @(negedge clk);
        check_wb(name, '0, wb_o);
        // Flushed store must not have reached memory.
        prog_q.push_back(make_ins(LDW, 32'h40, 32'h0, 32'h0, 1'b1));
        run_prog(name);
    endtask

    task automatic misaligned_access();
        be_issue_t ins;
        prog_q.push_back(make_ins(LDW, 32'h40, 32'h0, 32'h2, 1'b1));
        prog_q.push_back(make_ins(STW, 32'h80, $random(seed), 32'h1, 1'b0));
        prog_q.push_back(make_ins(LDW, 32'h80, 32'h0, 32'h0, 1'b1));
        ins       = make_ins(ADD, $random(seed), $random(seed), 32'h0, 1'b1);
        ins.excp  = 1'b1;
        ins.ecode = SYS;
        prog_q.push_back(ins);
        ins       = make_ins(CSRWR, 32'h0, $random(seed), 32'h0, 1'b1);
        ins.excp  = 1'b1;
        ins.ecode = BRK;
        prog_q.push_back(ins);
        ins       = make_ins(STB, 32'h80, $random(seed), 32'h2, 1'b0);
        ins.excp  = 1'b1;
        ins.ecode = INE;
        prog_q.push_back(ins);
        prog_q.push_back(make_ins(LDW, 32'h80, 32'h0, 32'h0, 1'b1));
        run_prog("misaligned");
    endtask

    task automatic csr_exchange();
        prog_q.push_back(make_ins(CSRWR, 32'h0, $random(seed), 32'h0, 1'b1));
        prog_q.push_back(make_ins(CSRRD, 32'h0, $random(seed), 32'h0, 1'b1));
        prog_q.push_back(make_ins(CSRWR, 32'h0, $random(seed), 32'h0, 1'b1));
        prog_q.push_back(make_ins(CSRRD, 32'h0, 32'h0, 32'h0, 1'b1));
        run_prog("csr");
    endtask

    initial begin
        rst_n_i      = 1'b0;
        stall_i      = 1'b0;
        flush_i      = 1'b0;
        excp_flush_i = 1'b0;
        ertn_flush_i = 1'b0;
        issue_i      = '0;
        csr_rdata_i  = '0;
        next_pc      = 32'h1c00_0000;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_wb("reset", '0, wb_o);
        run_alu_ops();
        mem_round_trip();
        stall_hold();
        flush_pulse("flush", 0);
        flush_pulse("excp flush", 1);
        flush_pulse("ertn flush", 2);
        misaligned_access();
        csr_exchange();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
